// File: dv/tb_clkgen.sv
// Testbench clock and reset
module tb_clkgen #(
   parameter int HALF_PERIOD  = 10,
   parameter int RESET_CYCLES = 5
) (
   output logic clk_o,
   output logic reset_o
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk_o = 1'b0;
      forever #(HALF_PERIOD) clk_o = ~clk_o;
   end

   initial begin
      reset_o = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_o);
      reset_o <= 1'b0;
   end

endmodule

// File: dv/tb_ncpu_core.sv
// Directed tests for the decode and execute slice
`include "ncpu_settings.svh"

module tb_ncpu_core;
   timeunit 1ns;
   timeprecision 100ps;
   import ncpu_pkg::*;

   localparam int         WATCHDOG_CYCLES = 2000;
   localparam int         READY_WAIT_MAX  = 16;
   localparam jmp_t       NO_JMP = '0;
   localparam retire_t    NO_RET = '0;

   logic                    clk;
   logic                    reset;
   logic                    insn_valid;
   insn_t                   insn;
   logic [`NCPU_AW-3:0]     insn_pc;
   logic                    insn_ready;
   jmp_t                    jmprel;
   jmp_t                    jmpreg;
   jmp_t                    emu;
   logic                    mem_valid;
   mem_req_t                mem_req;
   logic                    mem_ready;
   logic [`NCPU_DW-1:0]     mem_rdata;
   retire_t                 retire;

   int                      err_count;
   logic [31:0]             rng_state;
   logic [`NCPU_DW-1:0]     model [0:31];
   logic                    model_cc;
   logic [`NCPU_AW-3:0]     cur_pc;
   retire_t                 pend_ret;
   jmp_t                    pend_jreg;
   jmp_t                    pend_emu;

   tb_clkgen #(.HALF_PERIOD(10), .RESET_CYCLES(5)) clkgen_inst (
      .clk_o   (clk),
      .reset_o (reset)
   );

   ncpu_core ncpu_core_inst (
      .clk_i        (clk),
      .reset_i      (reset),
      .insn_valid_i (insn_valid),
      .insn_i       (insn),
      .insn_pc_i    (insn_pc),
      .insn_ready_o (insn_ready),
      .jmprel_o     (jmprel),
      .jmpreg_o     (jmpreg),
      .emu_o        (emu),
      .mem_valid_o  (mem_valid),
      .mem_req_o    (mem_req),
      .mem_ready_i  (mem_ready),
      .mem_rdata_i  (mem_rdata),
      .retire_o     (retire)
   );

   // xorshift32
   function automatic logic [31:0] next_rand();
      logic [31:0] x;
      x = rng_state;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      rng_state = x;
      return x;
   endfunction

   function automatic insn_t enc_reg(input logic [5:0] opc, input logic [4:0] rd,
                                     input logic [4:0] rs1, input logic [4:0] rs2);
      insn_t w;
      w = '0;
      w.reg_f.opcode = opc;
      w.reg_f.rd     = rd;
      w.reg_f.rs1    = rs1;
      w.reg_f.rs2    = rs2;
      return w;
   endfunction

   function automatic insn_t enc_imm(input logic [5:0] opc, input logic [4:0] rd,
                                     input logic [4:0] rs1, input logic [15:0] imm);
      insn_t w;
      w = '0;
      w.imm_f.opcode = opc;
      w.imm_f.rd     = rd;
      w.imm_f.rs1    = rs1;
      w.imm_f.imm16  = imm;
      return w;
   endfunction

   function automatic insn_t enc_rel(input logic [5:0] opc, input logic [4:0] rd,
                                     input logic [20:0] rel);
      insn_t w;
      w = '0;
      w.rel_f.opcode = opc;
      w.rel_f.rd     = rd;
      w.rel_f.rel21  = rel;
      return w;
   endfunction

   task automatic check_bit(input logic act, input logic exp, input string name);
      if (act !== exp) begin
         err_count++;
         $display("mismatch at %0t: %s got %b expected %b", $time, name, act, exp);
      end
   endtask

   task automatic check_retire(input retire_t act, input retire_t exp, input string name);
      if (act.valid !== exp.valid ||
          (exp.valid && (act.addr !== exp.addr || act.data !== exp.data))) begin
         err_count++;
         $display("mismatch at %0t: %s got %h expected %h", $time, name, act, exp);
      end
   endtask

   task automatic check_jmp(input jmp_t act, input jmp_t exp, input string name);
      if (act.valid !== exp.valid || (exp.valid && act.pc !== exp.pc)) begin
         err_count++;
         $display("mismatch at %0t: %s got %h expected %h", $time, name, act, exp);
      end
   endtask

   // Store data only matters for stores
   task automatic check_mem(input mem_req_t act, input mem_req_t exp, input string name);
      if (act.kind !== exp.kind || act.size !== exp.size || act.addr !== exp.addr ||
          act.ld_unsigned !== exp.ld_unsigned ||
          (exp.kind == MEM_STORE && act.wdata !== exp.wdata)) begin
         err_count++;
         $display("mismatch at %0t: %s got %h expected %h", $time, name, act, exp);
      end
   endtask

   // Outputs of the op now in execute
   task automatic check_exec();
      check_retire(retire, pend_ret, "retire_o");
      check_jmp(jmpreg, pend_jreg, "jmpreg_o");
      check_jmp(emu, pend_emu, "emu_o");
      pend_ret  = NO_RET;
      pend_jreg = NO_JMP;
      pend_emu  = NO_JMP;
   endtask

   task automatic present(input insn_t w);
      int n;
      insn_valid <= 1'b1;
      insn       <= w;
      insn_pc    <= cur_pc;
      @(negedge clk);
      check_exec();
      n = 0;
      while (insn_ready !== 1'b1) begin
         n++;
         if (n > READY_WAIT_MAX) begin
            err_count++;
            $display("Error at %0t: insn_ready_o stayed low too long", $time);
            break;
         end
         @(negedge clk);
      end
   endtask

   // Present one instruction; its execute outputs are checked one cycle later
   task automatic issue(input insn_t w, input retire_t exp_r, input jmp_t exp_jrel,
                        input jmp_t exp_jreg, input jmp_t exp_emu);
      present(w);
      check_jmp(jmprel, exp_jrel, "jmprel_o");
      @(posedge clk);
      pend_ret  = exp_r;
      pend_jreg = exp_jreg;
      pend_emu  = exp_emu;
      if (exp_r.valid)
         model[exp_r.addr] = exp_r.data;
      cur_pc = cur_pc + 30'd1;
   endtask

   task automatic alu(input insn_t w, input logic [4:0] rd, input logic [31:0] val);
      retire_t r;
      r = '{valid: (rd != 5'd0), addr: rd, data: val};
      issue(w, r, NO_JMP, NO_JMP, NO_JMP);
   endtask

   task automatic drain();
      insn_valid <= 1'b0;
      @(negedge clk);
      check_exec();
      @(posedge clk);
   endtask

   // Full 32-bit constant in three dependent steps
   task automatic load_const(input logic [4:0] rd, input logic [31:0] val);
      logic [31:0] hi_ext;
      hi_ext = {{16{val[31]}}, val[31:16]};
      alu(enc_imm(`NCPU_OP_ADD_I, rd, 5'd0, val[31:16]), rd, hi_ext);
      alu(enc_imm(`NCPU_OP_LSL_I, rd, rd, 16'd16), rd, hi_ext << 16);
      alu(enc_imm(`NCPU_OP_OR_I, rd, rd, val[15:0]), rd, (hi_ext << 16) | {16'h0, val[15:0]});
   endtask

   task automatic branch(input logic [5:0] opc, input logic [20:0] rel);
      jmp_t exp;
      logic taken;
      taken = (opc == `NCPU_OP_BT) ? model_cc : ~model_cc;
      exp   = '{valid: taken, pc: cur_pc + {{9{rel[20]}}, rel}};
      issue(enc_rel(opc, 5'd0, rel), NO_RET, exp, NO_JMP, NO_JMP);
   endtask

   // Memory op with a random ready delay of 0 to 3 cycles
   task automatic mem_access(input insn_t w, input mem_req_t q, input logic [31:0] rdata,
                             input retire_t r);
      int delay;
      delay = next_rand() % 32'd4;
      present(w);
      @(posedge clk);
      insn_valid <= 1'b0;
      cur_pc = cur_pc + 30'd1;
      for (int k = 0; k < delay; k++) begin
         @(negedge clk);
         check_bit(mem_valid, 1'b1, "mem_valid_o");
         check_mem(mem_req, q, "mem_req_o");
         check_bit(insn_ready, 1'b0, "insn_ready_o");
         check_retire(retire, NO_RET, "retire_o");
         @(posedge clk);
      end
      mem_ready <= 1'b1;
      mem_rdata <= rdata;
      @(negedge clk);
      check_bit(mem_valid, 1'b1, "mem_valid_o");
      check_mem(mem_req, q, "mem_req_o");
      check_bit(insn_ready, 1'b1, "insn_ready_o");
      check_retire(retire, r, "retire_o");
      @(posedge clk);
      mem_ready <= 1'b0;
      mem_rdata <= '0;
      if (r.valid)
         model[r.addr] = r.data;
   endtask

   task automatic mem_load(input logic [5:0] opc, input logic [4:0] rd, input logic [4:0] rs1,
                           input logic [1:0] size, input logic uns);
      logic [31:0] tmp;
      logic [31:0] rdata;
      logic [31:0] val;
      mem_req_t    q;
      retire_t     r;
      tmp      = next_rand();
      rdata    = next_rand();
      // Byte sign bit set so signed and unsigned loads differ
      rdata[7] = 1'b1;
      q = '{kind: MEM_LOAD, size: size, addr: model[rs1] + {{16{tmp[15]}}, tmp[15:0]},
            wdata: '0, ld_unsigned: uns};
      if (size == 2'd1)
         val = uns ? {24'h0, rdata[7:0]} : {{24{rdata[7]}}, rdata[7:0]};
      else
         val = rdata;
      r = '{valid: (rd != 5'd0), addr: rd, data: val};
      mem_access(enc_imm(opc, rd, rs1, tmp[15:0]), q, rdata, r);
   endtask

   task automatic mem_store(input logic [5:0] opc, input logic [4:0] src, input logic [4:0] rs1,
                            input logic [1:0] size);
      logic [31:0] tmp;
      mem_req_t    q;
      tmp = next_rand();
      q = '{kind: MEM_STORE, size: size, addr: model[rs1] + {{16{tmp[15]}}, tmp[15:0]},
            wdata: model[src], ld_unsigned: 1'b0};
      mem_access(enc_imm(opc, src, rs1, tmp[15:0]), q, next_rand(), NO_RET);
   endtask

   task automatic test_alu();
      for (int i = 1; i < 8; i++) begin
         load_const(5'(i), next_rand());
      end
      alu(enc_reg(`NCPU_OP_AND, 5'd8, 5'd1, 5'd2), 5'd8, model[1] & model[2]);
      alu(enc_reg(`NCPU_OP_OR, 5'd9, 5'd1, 5'd2), 5'd9, model[1] | model[2]);
      alu(enc_reg(`NCPU_OP_XOR, 5'd10, 5'd1, 5'd2), 5'd10, model[1] ^ model[2]);
      alu(enc_reg(`NCPU_OP_LSL, 5'd11, 5'd1, 5'd2), 5'd11, model[1] << model[2][4:0]);
      alu(enc_reg(`NCPU_OP_LSR, 5'd12, 5'd1, 5'd3), 5'd12, model[1] >> model[3][4:0]);
      alu(enc_reg(`NCPU_OP_ASR, 5'd13, 5'd4, 5'd3), 5'd13,
          32'($signed(model[4]) >>> model[3][4:0]));
      alu(enc_reg(`NCPU_OP_SUB, 5'd14, 5'd3, 5'd4), 5'd14, model[3] - model[4]);
      // Reads r14 straight behind its write
      alu(enc_reg(`NCPU_OP_ADD, 5'd15, 5'd14, 5'd5), 5'd15, model[14] + model[5]);
      drain();
   endtask

   task automatic test_imm();
      alu(enc_imm(`NCPU_OP_AND_I, 5'd16, 5'd1, 16'h8f0f), 5'd16, model[1] & 32'hffff8f0f);
      alu(enc_imm(`NCPU_OP_ADD_I, 5'd17, 5'd1, 16'hfff0), 5'd17, model[1] + 32'hfffffff0);
      alu(enc_imm(`NCPU_OP_OR_I, 5'd18, 5'd1, 16'h8001), 5'd18, model[1] | 32'h00008001);
      alu(enc_imm(`NCPU_OP_XOR_I, 5'd19, 5'd1, 16'h8000), 5'd19, model[1] ^ 32'hffff8000);
      alu(enc_imm(`NCPU_OP_ADD_I, 5'd0, 5'd1, 16'h0005), 5'd0, model[1] + 32'd5);
      // r0 must still read zero
      alu(enc_reg(`NCPU_OP_ADD, 5'd20, 5'd0, 5'd1), 5'd20, model[1]);
      drain();
   endtask

   task automatic test_branch();
      retire_t r;
      jmp_t    jr;
      issue(enc_reg(`NCPU_OP_CMP, 5'd0, 5'd1, 5'd1), NO_RET, NO_JMP, NO_JMP, NO_JMP);
      model_cc = 1'b1;
      branch(`NCPU_OP_BT, 21'd5);
      branch(`NCPU_OP_BF, 21'h1ffffd);
      issue(enc_reg(`NCPU_OP_CMP, 5'd0, 5'd1, 5'd2), NO_RET, NO_JMP, NO_JMP, NO_JMP);
      model_cc = (model[1] == model[2]);
      branch(`NCPU_OP_BT, 21'h1ffff0);
      branch(`NCPU_OP_BF, 21'd64);
      jr = '{valid: 1'b1, pc: cur_pc + 30'd100};
      r  = '{valid: 1'b1, addr: 5'd22, data: {2'b00, cur_pc + 30'd1}};
      issue(enc_rel(`NCPU_OP_JMP_I, 5'd22, 21'd100), r, jr, NO_JMP, NO_JMP);
      drain();
   endtask

   task automatic test_jmp_reg();
      retire_t r;
      jmp_t    jr;
      load_const(5'd23, next_rand());
      jr = '{valid: 1'b1, pc: model[23][31:2]};
      r  = '{valid: 1'b1, addr: 5'd24, data: {2'b00, cur_pc + 30'd1}};
      issue(enc_reg(`NCPU_OP_JMP, 5'd24, 5'd23, 5'd0), r, NO_JMP, jr, NO_JMP);
      drain();
   endtask

   task automatic test_mem();
      load_const(5'd25, next_rand());
      load_const(5'd26, next_rand());
      drain();
      mem_load(`NCPU_OP_LDB, 5'd27, 5'd25, 2'd1, 1'b0);
      mem_load(`NCPU_OP_LDBU, 5'd28, 5'd25, 2'd1, 1'b1);
      mem_load(`NCPU_OP_LDWU, 5'd29, 5'd26, 2'd3, 1'b1);
      mem_store(`NCPU_OP_STW, 5'd26, 5'd25, 2'd3);
      mem_store(`NCPU_OP_STB, 5'd27, 5'd26, 2'd1);
      drain();
   endtask

   task automatic test_emu();
      jmp_t e;
      e = '{valid: 1'b1, pc: cur_pc};
      issue(enc_reg(`NCPU_OP_MUL, 5'd3, 5'd1, 5'd2), NO_RET, NO_JMP, NO_JMP, e);
      e = '{valid: 1'b1, pc: cur_pc};
      issue(enc_reg(6'h3f, 5'd4, 5'd1, 5'd2), NO_RET, NO_JMP, NO_JMP, e);
      // r3 and r4 keep their old values
      alu(enc_reg(`NCPU_OP_ADD, 5'd5, 5'd3, 5'd4), 5'd5, model[3] + model[4]);
      drain();
   endtask

   initial begin
      insn_valid = 1'b0;
      insn       = '0;
      insn_pc    = '0;
      mem_ready  = 1'b0;
      mem_rdata  = '0;
      err_count  = 0;
      rng_state  = 32'd60850;
      model_cc   = 1'b0;
      cur_pc     = 30'h100;
      pend_ret   = NO_RET;
      pend_jreg  = NO_JMP;
      pend_emu   = NO_JMP;
      for (int i = 0; i < 32; i++) begin
         model[i] = '0;
      end
      @(posedge clk);
      while (reset !== 1'b0) begin
         @(posedge clk);
      end
      test_alu();
      test_imm();
      test_branch();
      test_jmp_reg();
      test_mem();
      test_emu();
      $display("Checks finished with %0d errors", err_count);
      if (err_count == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

   // Roughly twenty times the length of the directed sequence
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("Something failed");
      $finish;
   end

endmodule

// File: hdl/ncpu_core.sv
// Decode and execute slice
`include "ncpu_settings.svh"

module ncpu_core (
   input  logic                clk_i,
   input  logic                reset_i,
   input  logic                insn_valid_i,
   input  ncpu_pkg::insn_t     insn_i,
   input  logic [`NCPU_AW-3:0] insn_pc_i,
   output logic                insn_ready_o,
   output ncpu_pkg::jmp_t      jmprel_o,
   output ncpu_pkg::jmp_t      jmpreg_o,
   output ncpu_pkg::jmp_t      emu_o,
   output logic                mem_valid_o,
   output ncpu_pkg::mem_req_t  mem_req_o,
   input  logic                mem_ready_i,
   input  logic [`NCPU_DW-1:0] mem_rdata_i,
   output ncpu_pkg::retire_t   retire_o
);
   import ncpu_pkg::*;

   logic                    ex_ready;
   logic                    cc_next;
   logic                    op_valid;
   dec_op_t                 op;
   logic                    rs1_re;
   logic [`NCPU_REG_AW-1:0] rs1_addr;
   logic                    rs2_re;
   logic [`NCPU_REG_AW-1:0] rs2_addr;
   logic [`NCPU_DW-1:0]     rs1;
   logic [`NCPU_DW-1:0]     rs2;
   logic                    wb_we;
   logic [`NCPU_REG_AW-1:0] wb_addr;
   logic [`NCPU_DW-1:0]     wb_data;

   ncpu_idu idu_inst (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .insn_valid_i (insn_valid_i),
      .insn_i       (insn_i),
      .insn_pc_i    (insn_pc_i),
      .insn_ready_o (insn_ready_o),
      .ex_ready_i   (ex_ready),
      .cc_i         (cc_next),
      .jmprel_o     (jmprel_o),
      .rs1_re_o     (rs1_re),
      .rs1_addr_o   (rs1_addr),
      .rs2_re_o     (rs2_re),
      .rs2_addr_o   (rs2_addr),
      .op_valid_o   (op_valid),
      .op_o         (op)
   );

   ncpu_regfile regfile_inst (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .rs1_re_i   (rs1_re),
      .rs1_addr_i (rs1_addr),
      .rs1_o      (rs1),
      .rs2_re_i   (rs2_re),
      .rs2_addr_i (rs2_addr),
      .rs2_o      (rs2),
      .we_i       (wb_we),
      .waddr_i    (wb_addr),
      .wdata_i    (wb_data)
   );

   ncpu_ieu ieu_inst (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .op_valid_i  (op_valid),
      .op_i        (op),
      .rs1_i       (rs1),
      .rs2_i       (rs2),
      .ex_ready_o  (ex_ready),
      .cc_next_o   (cc_next),
      .mem_valid_o (mem_valid_o),
      .mem_req_o   (mem_req_o),
      .mem_ready_i (mem_ready_i),
      .mem_rdata_i (mem_rdata_i),
      .jmpreg_o    (jmpreg_o),
      .emu_o       (emu_o),
      .wb_we_o     (wb_we),
      .wb_addr_o   (wb_addr),
      .wb_data_o   (wb_data),
      .retire_o    (retire_o)
   );

endmodule

// File: hdl/ncpu_idu.sv
// Instruction decode unit
`include "ncpu_settings.svh"

module ncpu_idu (
   input  logic                    clk_i,
   input  logic                    reset_i,
   input  logic                    insn_valid_i,
   input  ncpu_pkg::insn_t         insn_i,
   input  logic [`NCPU_AW-3:0]     insn_pc_i,
   output logic                    insn_ready_o,
   input  logic                    ex_ready_i,
   input  logic                    cc_i,
   output ncpu_pkg::jmp_t          jmprel_o,
   output logic                    rs1_re_o,
   output logic [`NCPU_REG_AW-1:0] rs1_addr_o,
   output logic                    rs2_re_o,
   output logic [`NCPU_REG_AW-1:0] rs2_addr_o,
   output logic                    op_valid_o,
   output ncpu_pkg::dec_op_t       op_o
);
   import ncpu_pkg::*;

   wire [5:0]  opc    = insn_i.reg_f.opcode;
   wire [15:0] imm16  = insn_i.imm_f.imm16;
   wire [20:0] rel21  = insn_i.rel_f.rel21;
   wire        accept = insn_valid_i & ex_ready_i;

   wire op_and   = (opc == `NCPU_OP_AND);
   wire op_and_i = (opc == `NCPU_OP_AND_I);
   wire op_or    = (opc == `NCPU_OP_OR);
   wire op_or_i  = (opc == `NCPU_OP_OR_I);
   wire op_xor   = (opc == `NCPU_OP_XOR);
   wire op_xor_i = (opc == `NCPU_OP_XOR_I);
   wire op_lsl   = (opc == `NCPU_OP_LSL);
   wire op_lsl_i = (opc == `NCPU_OP_LSL_I);
   wire op_lsr   = (opc == `NCPU_OP_LSR);
   wire op_lsr_i = (opc == `NCPU_OP_LSR_I);
   wire op_asr   = (opc == `NCPU_OP_ASR) & `ENABLE_ASR;
   wire op_asr_i = (opc == `NCPU_OP_ASR_I) & `ENABLE_ASR;

   wire op_add   = (opc == `NCPU_OP_ADD);
   wire op_add_i = (opc == `NCPU_OP_ADD_I);
   wire op_sub   = (opc == `NCPU_OP_SUB) & `ENABLE_SUB;
   wire op_cmp   = (opc == `NCPU_OP_CMP);

   wire op_ldb   = (opc == `NCPU_OP_LDB) & `ENABLE_LDB;
   wire op_ldbu  = (opc == `NCPU_OP_LDBU) & `ENABLE_LDBU;
   wire op_ldh   = (opc == `NCPU_OP_LDH) & `ENABLE_LDH;
   wire op_ldhu  = (opc == `NCPU_OP_LDHU) & `ENABLE_LDHU;
   wire op_ldwu  = (opc == `NCPU_OP_LDWU);
   wire op_stb   = (opc == `NCPU_OP_STB) & `ENABLE_STB;
   wire op_sth   = (opc == `NCPU_OP_STH) & `ENABLE_STH;
   wire op_stw   = (opc == `NCPU_OP_STW);
   wire op_barr  = (opc == `NCPU_OP_BARR);

   wire op_jmp   = (opc == `NCPU_OP_JMP);
   wire op_jmp_i = (opc == `NCPU_OP_JMP_I);
   wire op_bt    = (opc == `NCPU_OP_BT);
   wire op_bf    = (opc == `NCPU_OP_BF);

   wire op_load  = op_ldb | op_ldbu | op_ldh | op_ldhu | op_ldwu;
   wire op_store = op_stb | op_sth | op_stw;
   wire op_byte  = op_ldb | op_ldbu | op_stb;
   wire op_half  = op_ldh | op_ldhu | op_sth;
   wire op_word  = op_ldwu | op_stw;

   wire lu_imm = op_and_i | op_or_i | op_xor_i | op_lsl_i | op_lsr_i | op_asr_i;
   wire lu_any = op_and | op_or | op_xor | op_lsl | op_lsr | op_asr | lu_imm;
   wire au_any = op_add | op_add_i | op_sub | op_cmp;
   wire bu_any = op_jmp | op_jmp_i | op_bt | op_bf;

   // No unit claims the opcode
   wire emu = ~(lu_any | au_any | bu_any | op_load | op_store | op_barr);

   wire use_imm    = lu_imm | op_add_i | op_load | op_store;
   wire imm_signed = op_xor_i | op_and_i | op_add_i | op_load | op_store;
   wire no_rs1     = op_barr | op_jmp_i | op_bt | op_bf | emu;

   wire [`NCPU_DW-1:0]  imm_ext = imm_signed ? {{(`NCPU_DW-16){imm16[15]}}, imm16}
                                             : {{(`NCPU_DW-16){1'b0}}, imm16};
   wire [`NCPU_AW-3:0]  rel_off = {{(`NCPU_AW-23){rel21[20]}}, rel21};

   dec_op_t dec;

   always_comb begin
      dec             = '0;
      dec.lu.and_op   = op_and | op_and_i;
      dec.lu.or_op    = op_or | op_or_i;
      dec.lu.xor_op   = op_xor | op_xor_i;
      dec.lu.lsl_op   = op_lsl | op_lsl_i;
      dec.lu.lsr_op   = op_lsr | op_lsr_i;
      dec.lu.asr_op   = op_asr | op_asr_i;
      dec.au.add_op   = op_add | op_add_i;
      dec.au.sub_op   = op_sub;
      dec.au.cmp_op   = op_cmp;
      if (op_load)
         dec.mem_kind = MEM_LOAD;
      else if (op_store)
         dec.mem_kind = MEM_STORE;
      else if (op_barr)
         dec.mem_kind = MEM_BARRIER;
      else
         dec.mem_kind = MEM_NONE;
      dec.size        = op_byte ? 2'd1 : op_half ? 2'd2 : op_word ? 2'd3 : 2'd0;
      dec.ld_unsigned = op_ldbu | op_ldhu | op_ldwu;
      dec.use_imm     = use_imm;
      dec.imm         = imm_ext;
      dec.wb_en       = lu_any | op_add | op_add_i | op_sub | op_load | op_jmp | op_jmp_i;
      dec.wb_addr     = insn_i.reg_f.rd;
      dec.jmp_reg     = op_jmp;
      dec.jmp_link    = op_jmp | op_jmp_i;
      dec.emu         = emu;
      dec.pc          = insn_pc_i;
   end

   // Relative jumps go back to fetch in the accept cycle
   assign jmprel_o = '{valid: accept & (op_jmp_i | (op_bt & cc_i) | (op_bf & ~cc_i)),
                       pc:    insn_pc_i + rel_off};

   // Reads only on acceptance so operands hold during back-pressure
   assign rs1_re_o   = accept & ~no_rs1;
   assign rs1_addr_o = insn_i.reg_f.rs1;
   assign rs2_re_o   = accept & (op_store | (~use_imm & (lu_any | au_any)));
   // Store source sits in rd
   assign rs2_addr_o = op_store ? insn_i.reg_f.rd : insn_i.reg_f.rs2;

   assign insn_ready_o = ex_ready_i;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         op_valid_o <= 1'b0;
      end else if (ex_ready_i) begin
         op_valid_o <= insn_valid_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (ex_ready_i) begin
         op_o <= dec;
      end
   end

endmodule

// File: hdl/ncpu_ieu.sv
// Integer execute unit
`include "ncpu_settings.svh"

module ncpu_ieu (
   input  logic                    clk_i,
   input  logic                    reset_i,
   input  logic                    op_valid_i,
   input  ncpu_pkg::dec_op_t       op_i,
   input  logic [`NCPU_DW-1:0]     rs1_i,
   input  logic [`NCPU_DW-1:0]     rs2_i,
   output logic                    ex_ready_o,
   output logic                    cc_next_o,
   output logic                    mem_valid_o,
   output ncpu_pkg::mem_req_t      mem_req_o,
   input  logic                    mem_ready_i,
   input  logic [`NCPU_DW-1:0]     mem_rdata_i,
   output ncpu_pkg::jmp_t          jmpreg_o,
   output ncpu_pkg::jmp_t          emu_o,
   output logic                    wb_we_o,
   output logic [`NCPU_REG_AW-1:0] wb_addr_o,
   output logic [`NCPU_DW-1:0]     wb_data_o,
   output ncpu_pkg::retire_t       retire_o
);
   import ncpu_pkg::*;

   logic [`NCPU_DW-1:0] lu_res;
   logic [`NCPU_DW-1:0] ld_data;
   logic                cc_q;

   wire [`NCPU_DW-1:0] opnd1 = rs1_i;
   wire [`NCPU_DW-1:0] opnd2 = op_i.use_imm ? op_i.imm : rs2_i;
   wire [4:0]          shamt = opnd2[4:0];

   // Adder shared by ADD and the memory address
   wire [`NCPU_DW-1:0] sum  = opnd1 + opnd2;
   wire [`NCPU_DW-1:0] diff = opnd1 - opnd2;

   // Arithmetic right shift fills with the sign bit
   wire [`NCPU_DW-1:0] asr_res = $signed(opnd1) >>> shamt;

   // One-hot logic unit
   always_comb begin
      lu_res = '0;
      if (op_i.lu.and_op)
         lu_res = lu_res | (opnd1 & opnd2);
      if (op_i.lu.or_op)
         lu_res = lu_res | (opnd1 | opnd2);
      if (op_i.lu.xor_op)
         lu_res = lu_res | (opnd1 ^ opnd2);
      if (op_i.lu.lsl_op)
         lu_res = lu_res | (opnd1 << shamt);
      if (op_i.lu.lsr_op)
         lu_res = lu_res | (opnd1 >> shamt);
      if (op_i.lu.asr_op)
         lu_res = lu_res | asr_res;
   end

   wire lu_sel = |op_i.lu;
   wire [`NCPU_DW-1:0] au_res = op_i.au.sub_op ? diff : sum;

   // Flag updates in the CMP cycle so a following branch sees it
   wire cmp_now = op_valid_i & op_i.au.cmp_op;
   assign cc_next_o = cmp_now ? (opnd1 == opnd2) : cc_q;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         cc_q <= 1'b0;
      end else begin
         cc_q <= cc_next_o;
      end
   end

   // Request held by stalling decode until ready
   wire is_mem   = op_i.mem_kind != MEM_NONE;
   wire mem_done = mem_valid_o & mem_ready_i;

   assign mem_valid_o = op_valid_i & is_mem;
   assign ex_ready_o  = ~mem_valid_o | mem_ready_i;
   assign mem_req_o   = '{kind:        op_i.mem_kind,
                          size:        op_i.size,
                          addr:        sum,
                          wdata:       rs2_i,
                          ld_unsigned: op_i.ld_unsigned};

   // Load data extension by size
   always_comb begin
      case (op_i.size)
         2'd1: begin
            ld_data = op_i.ld_unsigned ? {{(`NCPU_DW-8){1'b0}}, mem_rdata_i[7:0]}
                                       : {{(`NCPU_DW-8){mem_rdata_i[7]}}, mem_rdata_i[7:0]};
         end
         2'd2: begin
            ld_data = op_i.ld_unsigned ? {{(`NCPU_DW-16){1'b0}}, mem_rdata_i[15:0]}
                                       : {{(`NCPU_DW-16){mem_rdata_i[15]}}, mem_rdata_i[15:0]};
         end
         default: ld_data = mem_rdata_i;
      endcase
   end

   // Link value is the next word-address PC
   wire [`NCPU_AW-3:0] pc_next  = op_i.pc + {{(`NCPU_AW-3){1'b0}}, 1'b1};
   wire [`NCPU_DW-1:0] link_val = {2'b00, pc_next};

   wire alu_we = op_valid_i & op_i.wb_en & ~is_mem;
   wire ld_we  = mem_done & op_i.wb_en & (op_i.mem_kind == MEM_LOAD);

   assign wb_we_o   = alu_we | ld_we;
   assign wb_addr_o = op_i.wb_addr;

   always_comb begin
      if (is_mem)
         wb_data_o = ld_data;
      else if (op_i.jmp_link)
         wb_data_o = link_val;
      else if (lu_sel)
         wb_data_o = lu_res;
      else
         wb_data_o = au_res;
   end

   // r0 writes are dropped by the register file
   assign retire_o = '{valid: wb_we_o & (wb_addr_o != '0),
                       addr:  wb_addr_o,
                       data:  wb_data_o};

   assign jmpreg_o = '{valid: op_valid_i & op_i.jmp_reg,
                       pc:    opnd1[`NCPU_DW-1:2]};

   assign emu_o = '{valid: op_valid_i & op_i.emu,
                    pc:    op_i.pc};

endmodule

// File: hdl/ncpu_pkg.sv
// Shared decode and execute types
`include "ncpu_settings.svh"

package ncpu_pkg;

   // Register form
   typedef struct packed {
      logic [10:0]             attr;
      logic [`NCPU_REG_AW-1:0] rs2;
      logic [`NCPU_REG_AW-1:0] rs1;
      logic [`NCPU_REG_AW-1:0] rd;
      logic [5:0]              opcode;
   } insn_reg_t;

   // Immediate form
   typedef struct packed {
      logic [15:0]             imm16;
      logic [`NCPU_REG_AW-1:0] rs1;
      logic [`NCPU_REG_AW-1:0] rd;
      logic [5:0]              opcode;
   } insn_imm_t;

   // PC-relative form
   typedef struct packed {
      logic [20:0]             rel21;
      logic [`NCPU_REG_AW-1:0] rd;
      logic [5:0]              opcode;
   } insn_rel_t;

   typedef union packed {
      insn_reg_t reg_f;
      insn_imm_t imm_f;
      insn_rel_t rel_f;
   } insn_t;

   // One-hot logic unit select
   typedef struct packed {
      logic and_op;
      logic or_op;
      logic xor_op;
      logic lsl_op;
      logic lsr_op;
      logic asr_op;
   } lu_op_t;

   typedef struct packed {
      logic add_op;
      logic sub_op;
      logic cmp_op;
   } au_op_t;

   typedef enum logic [1:0] {
      MEM_NONE,
      MEM_LOAD,
      MEM_STORE,
      MEM_BARRIER
   } mem_kind_t;

   // Decode/execute register
   typedef struct packed {
      lu_op_t                  lu;
      au_op_t                  au;
      mem_kind_t               mem_kind;
      logic [1:0]              size;       // 0 none, 1 byte, 2 half, 3 word
      logic                    ld_unsigned;
      logic                    use_imm;
      logic [`NCPU_DW-1:0]     imm;
      logic                    wb_en;
      logic [`NCPU_REG_AW-1:0] wb_addr;
      logic                    jmp_reg;
      logic                    jmp_link;
      logic                    emu;
      logic [`NCPU_AW-3:0]     pc;
   } dec_op_t;

   typedef struct packed {
      mem_kind_t           kind;
      logic [1:0]          size;
      logic [`NCPU_AW-1:0] addr;
      logic [`NCPU_DW-1:0] wdata;
      logic                ld_unsigned;
   } mem_req_t;

   typedef struct packed {
      logic                valid;
      logic [`NCPU_AW-3:0] pc;
   } jmp_t;

   typedef struct packed {
      logic                    valid;
      logic [`NCPU_REG_AW-1:0] addr;
      logic [`NCPU_DW-1:0]     data;
   } retire_t;

endpackage

// File: hdl/ncpu_regfile.sv
// Register file with two read ports
`include "ncpu_settings.svh"

module ncpu_regfile (
   input  logic                    clk_i,
   input  logic                    reset_i,
   input  logic                    rs1_re_i,
   input  logic [`NCPU_REG_AW-1:0] rs1_addr_i,
   output logic [`NCPU_DW-1:0]     rs1_o,
   input  logic                    rs2_re_i,
   input  logic [`NCPU_REG_AW-1:0] rs2_addr_i,
   output logic [`NCPU_DW-1:0]     rs2_o,
   input  logic                    we_i,
   input  logic [`NCPU_REG_AW-1:0] waddr_i,
   input  logic [`NCPU_DW-1:0]     wdata_i
);

   logic [`NCPU_DW-1:0] regs [0:(1<<`NCPU_REG_AW)-1];

   // Write-first read with r0 hardwired to zero
   function automatic logic [`NCPU_DW-1:0] read_port(input logic [`NCPU_REG_AW-1:0] addr);
      if (addr == '0)
         return '0;
      if (we_i && waddr_i == addr)
         return wdata_i;
      return regs[addr];
   endfunction

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         for (int i = 0; i < (1 << `NCPU_REG_AW); i++) begin
            regs[i] <= '0;
         end
         rs1_o <= '0;
         rs2_o <= '0;
      end else begin
         if (we_i && waddr_i != '0)
            regs[waddr_i] <= wdata_i;
         if (rs1_re_i)
            rs1_o <= read_port(rs1_addr_i);
         if (rs2_re_i)
            rs2_o <= read_port(rs2_addr_i);
      end
   end

endmodule

// File: hdl/ncpu_settings.svh
// Core widths, opcodes and build options
`ifndef NCPU_SETTINGS_SVH
`define NCPU_SETTINGS_SVH

`define NCPU_DW      32
`define NCPU_AW      32
`define NCPU_REG_AW  5

// Logic unit
`define NCPU_OP_AND    6'h01
`define NCPU_OP_AND_I  6'h02
`define NCPU_OP_OR     6'h03
`define NCPU_OP_OR_I   6'h04
`define NCPU_OP_XOR    6'h05
`define NCPU_OP_XOR_I  6'h06
`define NCPU_OP_LSL    6'h07
`define NCPU_OP_LSL_I  6'h08
`define NCPU_OP_LSR    6'h09
`define NCPU_OP_LSR_I  6'h0a
`define NCPU_OP_ASR    6'h0b
`define NCPU_OP_ASR_I  6'h0c

// Arithmetic unit
// MUL has no unit and always goes to emulation
`define NCPU_OP_ADD    6'h0d
`define NCPU_OP_ADD_I  6'h0e
`define NCPU_OP_SUB    6'h0f
`define NCPU_OP_MUL    6'h10
`define NCPU_OP_CMP    6'h11

// Memory unit
`define NCPU_OP_LDB    6'h18
`define NCPU_OP_LDBU   6'h19
`define NCPU_OP_LDH    6'h1a
`define NCPU_OP_LDHU   6'h1b
`define NCPU_OP_LDWU   6'h1c
`define NCPU_OP_STB    6'h1d
`define NCPU_OP_STH    6'h1e
`define NCPU_OP_STW    6'h1f
`define NCPU_OP_BARR   6'h20

// Branch unit
`define NCPU_OP_JMP    6'h21
`define NCPU_OP_JMP_I  6'h22
`define NCPU_OP_BT     6'h23
`define NCPU_OP_BF     6'h24

// Optional instructions
// A value of 1'b0 sends the opcode to emulation
`define ENABLE_ASR   1'b1
`define ENABLE_SUB   1'b1
`define ENABLE_LDB   1'b1
`define ENABLE_LDBU  1'b1
`define ENABLE_LDH   1'b1
`define ENABLE_LDHU  1'b1
`define ENABLE_STB   1'b1
`define ENABLE_STH   1'b1

`endif

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module tb_ncpu_core \
   --Mdir obj_dir -o tb_ncpu_core

out=$(./obj_dir/tb_ncpu_core)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Everything OK"; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi

// File: sim.f
+incdir+hdl
hdl/ncpu_pkg.sv
hdl/ncpu_idu.sv
hdl/ncpu_regfile.sv
hdl/ncpu_ieu.sv
hdl/ncpu_core.sv
dv/tb_clkgen.sv
dv/tb_ncpu_core.sv
